// File: rtl/isa_pkg.sv
package isa_pkg;

    typedef logic [31:0] instr_t;                           // Raw instruction register contents

    // Major opcodes in bits 6:0
    localparam logic [6:0] opcode_op          = 7'd51;      // R-type ALU
    localparam logic [6:0] opcode_op_imm      = 7'd19;      // I-type ALU and nop
    localparam logic [6:0] opcode_load        = 7'd3;       // All load widths
    localparam logic [6:0] opcode_store       = 7'd35;      // All store widths
    localparam logic [6:0] opcode_branch      = 7'd99;      // beq only
    localparam logic [6:0] opcode_branch_jalr = 7'd103;     // bne, bge, blt and jalr share it
    localparam logic [6:0] opcode_lui         = 7'd55;      // U-type
    localparam logic [6:0] opcode_jal         = 7'd111;     // UJ-type
    localparam logic [6:0] opcode_system      = 7'd115;     // break

    // funct3 field in bits 14:12
    localparam logic [2:0] funct3_add_sub = 3'd0;           // add and sub split by funct7
    localparam logic [2:0] funct3_slt     = 3'd2;
    localparam logic [2:0] funct3_and     = 3'd7;
    localparam logic [2:0] funct3_addi    = 3'd0;
    localparam logic [2:0] funct3_slti    = 3'd2;
    localparam logic [2:0] funct3_lb      = 3'd0;
    localparam logic [2:0] funct3_lh      = 3'd1;
    localparam logic [2:0] funct3_lw      = 3'd2;
    localparam logic [2:0] funct3_ld      = 3'd3;
    localparam logic [2:0] funct3_lbu     = 3'd4;
    localparam logic [2:0] funct3_lhu     = 3'd5;
    localparam logic [2:0] funct3_lwu     = 3'd6;
    localparam logic [2:0] funct3_sb      = 3'd0;
    localparam logic [2:0] funct3_sh      = 3'd1;
    localparam logic [2:0] funct3_sw      = 3'd2;
    localparam logic [2:0] funct3_sd      = 3'd7;           // Nonstandard slot in this ISA map
    localparam logic [2:0] funct3_beq     = 3'd0;
    localparam logic [2:0] funct3_jalr    = 3'd0;
    localparam logic [2:0] funct3_bne     = 3'd1;
    localparam logic [2:0] funct3_blt     = 3'd4;
    localparam logic [2:0] funct3_bge     = 3'd5;

    // funct7 field in bits 31:25
    localparam logic [6:0] funct7_base = 7'd0;              // add, and, slt
    localparam logic [6:0] funct7_sub  = 7'd32;             // sub

    typedef enum logic [4:0] {
        class_add, class_sub, class_and, class_slt,         // R-type
        class_addi, class_slti, class_lui,                  // Immediate forms
        class_load, class_store,                            // One class per memory direction
        class_beq, class_bne, class_bge, class_blt,         // Conditional branches
        class_jal, class_jalr,                              // Jumps with link
        class_nop, class_break,
        class_illegal                                       // Anything not matched
    } instr_class_t;

endpackage

// File: rtl/control_pkg.sv
package control_pkg;

    // Controller states in FSM encoding order
    typedef enum logic [3:0] {
        state_fetch          = 4'd1,                        // PC + 4 while the word is latched outside
        state_decode         = 4'd2,                        // Operand latch and class dispatch
        state_branch         = 4'd3,                        // Branch target computed and written
        state_write_back     = 4'd4,                        // ALU result to rd
        state_mem_write_back = 4'd5,                        // Memory data to rd
        state_compare        = 4'd6,                        // slt result from menor
        state_mem_read       = 4'd7,                        // Data memory access for loads
        state_mem_write      = 4'd8,                        // Data memory write for stores
        state_wait           = 4'd9                         // Lets the loaded value settle in rd
    } ctrl_state_t;

    typedef enum logic [2:0] {
        alu_pass_a    = 3'd0,                               // Result is operand A
        alu_add       = 3'd1,
        alu_sub       = 3'd2,
        alu_and       = 3'd3,
        alu_increment = 3'd4,                               // A + 1
        alu_compare   = 3'd7                                // Sets igual and menor
    } alu_op_t;

    typedef enum logic [2:0] {
        src_a_pc    = 3'd0,
        src_a_reg_a = 3'd1
    } src_a_t;

    typedef enum logic [2:0] {
        src_b_reg_b         = 3'd0,
        src_b_four          = 3'd1,                         // Constant 4 for PC increment
        src_b_immediate     = 3'd2,                         // Sign-extended immediate
        src_b_branch_offset = 3'd3                          // Shifted branch or jump offset
    } src_b_t;

    typedef enum logic [2:0] {
        wb_alu    = 3'd0,                                   // Register file takes ALU out
        wb_memory = 3'd1                                    // Register file takes memory data reg
    } wb_sel_t;

endpackage

// File: rtl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import isa_pkg::*; (
    input  instr_t       instruction,
    output instr_class_t instr_class
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    always_comb begin
        instr_class = class_illegal;                        // Fallback for every unmatched word
        case (opcode)
            opcode_op: begin
                if (funct3 == funct3_add_sub && funct7 == funct7_base) begin
                    instr_class = class_add;
                end else if (funct3 == funct3_add_sub && funct7 == funct7_sub) begin
                    instr_class = class_sub;
                end else if (funct3 == funct3_and && funct7 == funct7_base) begin
                    instr_class = class_and;
                end else if (funct3 == funct3_slt && funct7 == funct7_base) begin
                    instr_class = class_slt;
                end
            end
            opcode_op_imm: begin
                if (instruction[31:7] == '0) begin          // addi x0, x0, 0
                    instr_class = class_nop;
                end else if (funct3 == funct3_addi) begin
                    instr_class = class_addi;
                end else if (funct3 == funct3_slti) begin
                    instr_class = class_slti;
                end                                         // Shift immediates end up illegal
            end
            opcode_load: begin
                case (funct3)
                    funct3_ld, funct3_lb, funct3_lh, funct3_lw,
                    funct3_lbu, funct3_lhu, funct3_lwu: instr_class = class_load;
                    default: instr_class = class_illegal;   // funct3 7 has no load
                endcase
            end
            opcode_store: begin
                case (funct3)
                    funct3_sd, funct3_sw, funct3_sh, funct3_sb: instr_class = class_store;
                    default: instr_class = class_illegal;
                endcase
            end
            opcode_branch: begin
                if (funct3 == funct3_beq) begin
                    instr_class = class_beq;
                end
            end
            opcode_branch_jalr: begin
                case (funct3)
                    funct3_bne:  instr_class = class_bne;
                    funct3_jalr: instr_class = class_jalr;
                    funct3_bge:  instr_class = class_bge;
                    funct3_blt:  instr_class = class_blt;
                    default:     instr_class = class_illegal;
                endcase
            end
            opcode_lui:    instr_class = class_lui;         // No sub-fields to check
            opcode_jal:    instr_class = class_jal;
            opcode_system: instr_class = class_break;       // Any system word parks the unit
            default:       instr_class = class_illegal;
        endcase
    end

endmodule

// File: rtl/control_sequencer.sv
`timescale 1ns/1ps

module control_sequencer import isa_pkg::*, control_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  instr_class_t instr_class,
    output ctrl_state_t  state
);

    ctrl_state_t next_state;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= state_fetch;
        end else begin
            state <= next_state;                            // One state per cycle, no stalls
        end
    end

    always_comb begin
        next_state = state_fetch;                           // Most paths end back in fetch
        case (state)
            state_fetch: next_state = state_decode;
            state_decode: begin
                case (instr_class)
                    class_add, class_sub, class_and,
                    class_addi, class_lui,
                    class_jal, class_jalr:  next_state = state_write_back; // Jumps link first
                    class_slt, class_slti:  next_state = state_compare;
                    class_load:             next_state = state_mem_read;
                    class_store:            next_state = state_mem_write;
                    class_beq, class_bne,
                    class_bge, class_blt:   next_state = state_branch;
                    class_break:            next_state = state_decode;     // Parked while present
                    default:                next_state = state_fetch;      // nop and illegal
                endcase
            end
            state_compare: next_state = state_write_back;
            state_write_back: begin
                if (instr_class == class_jal || instr_class == class_jalr) begin
                    next_state = state_branch;              // Link written, now jump
                end else begin
                    next_state = state_fetch;
                end
            end
            state_mem_read:       next_state = state_mem_write_back;
            state_mem_write_back: next_state = state_wait;
            state_wait:           next_state = state_fetch;
            state_mem_write:      next_state = state_fetch;
            state_branch:         next_state = state_fetch;
            default:              next_state = state_fetch; // Recover from unused codes
        endcase
    end

endmodule

// File: rtl/datapath_control.sv
`timescale 1ns/1ps

module datapath_control import isa_pkg::*, control_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  ctrl_state_t  state,
    input  instr_class_t instr_class,
    input  logic         igual,
    input  logic         menor,
    output logic         pc_write,
    output logic         operand_latch,
    output logic         clear_a,
    output logic         reg_file_wr,
    output logic         data_memory_wr,
    output logic         mem_data_wr,
    output alu_op_t      alu_op,
    output src_a_t       src_a,
    output src_b_t       src_b,
    output wb_sel_t      wb_sel
);

    logic branch_taken;

    // Branch condition from the comparator flags of the decode-cycle compare
    always_comb begin
        case (instr_class)
            class_beq:             branch_taken = igual;
            class_bne:             branch_taken = !igual;
            class_bge:             branch_taken = !menor;  // Not less means greater or equal
            class_blt:             branch_taken = menor;
            class_jal, class_jalr: branch_taken = 1'b1;    // Unconditional
            default:               branch_taken = 1'b0;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc_write       <= 1'b0;
            operand_latch  <= 1'b0;
            clear_a        <= 1'b1;                         // A held at zero through reset
            reg_file_wr    <= 1'b0;
            data_memory_wr <= 1'b0;
            mem_data_wr    <= 1'b0;
            alu_op         <= alu_pass_a;
            src_a          <= src_a_pc;
            src_b          <= src_b_reg_b;
            wb_sel         <= wb_alu;
        end else begin
            pc_write       <= 1'b0;                         // Strobes are one-cycle pulses
            clear_a        <= 1'b0;
            reg_file_wr    <= 1'b0;
            data_memory_wr <= 1'b0;
            mem_data_wr    <= 1'b0;
            case (state)
                state_fetch: begin
                    pc_write      <= 1'b1;                  // PC <= PC + 4
                    alu_op        <= alu_add;
                    src_a         <= src_a_pc;
                    src_b         <= src_b_four;
                    operand_latch <= 1'b0;
                    wb_sel        <= wb_memory;
                end
                state_decode: begin
                    operand_latch <= 1'b1;                  // Capture rs1 and rs2 into A and B
                    case (instr_class)
                        class_add, class_sub, class_and: begin
                            src_a <= src_a_reg_a;
                            src_b <= src_b_reg_b;
                            if (instr_class == class_add) begin
                                alu_op <= alu_add;
                            end else if (instr_class == class_sub) begin
                                alu_op <= alu_sub;
                            end else begin
                                alu_op <= alu_and;
                            end
                        end
                        class_slt, class_slti: begin
                            alu_op <= alu_compare;          // Result taken from menor later
                            src_a  <= src_a_reg_a;
                            if (instr_class == class_slt) begin
                                src_b <= src_b_reg_b;
                            end else begin
                                src_b <= src_b_immediate;
                            end
                        end
                        class_addi, class_lui, class_load, class_store: begin
                            alu_op <= alu_add;              // rs1 + imm, or address
                            src_a  <= src_a_reg_a;
                            src_b  <= src_b_immediate;
                            if (instr_class == class_lui) begin
                                clear_a <= 1'b1;            // Zero + upper immediate
                            end
                            if (instr_class == class_load) begin
                                mem_data_wr <= 1'b1;
                            end
                        end
                        class_beq, class_bne, class_bge, class_blt: begin
                            alu_op <= alu_compare;          // Produces igual and menor
                            src_a  <= src_a_reg_a;
                            src_b  <= src_b_reg_b;
                        end
                        class_jal, class_jalr: begin
                            alu_op <= alu_pass_a;           // Link value is the current PC
                            src_a  <= src_a_pc;
                        end
                        default: begin
                        end                                 // nop, break and illegal only latch
                    endcase
                end
                state_compare: begin
                    clear_a <= 1'b1;                        // A becomes 0, then 0 or 1 out
                    src_a   <= src_a_reg_a;
                    alu_op  <= menor ? alu_increment : alu_pass_a;
                end
                state_write_back: begin
                    wb_sel      <= wb_alu;
                    reg_file_wr <= 1'b1;
                end
                state_mem_write_back: begin
                    wb_sel      <= wb_memory;
                    reg_file_wr <= 1'b1;
                end
                state_mem_write: data_memory_wr <= 1'b1;
                state_branch: begin
                    if (branch_taken) begin
                        pc_write <= 1'b1;
                        alu_op   <= alu_add;
                        if (instr_class == class_jalr) begin
                            src_a <= src_a_reg_a;           // rs1 + imm
                            src_b <= src_b_immediate;
                        end else begin
                            src_a <= src_a_pc;              // PC + offset
                            src_b <= src_b_branch_offset;
                        end
                    end
                end
                default: begin
                end                                         // Memory read and wait drive nothing
            endcase
        end
    end

endmodule

// File: rtl/control_unit.sv
`timescale 1ns/1ps

module control_unit import isa_pkg::*, control_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        igual,                              // A equals B
    input  logic        menor,                              // A less than B
    input  instr_t      instruction,
    output ctrl_state_t state,
    output logic        pc_write,
    output logic        operand_latch,
    output logic        clear_a,
    output logic        reg_file_wr,
    output logic        data_memory_wr,
    output logic        mem_data_wr,
    output alu_op_t     alu_op,
    output src_a_t      src_a,
    output src_b_t      src_b,
    output wb_sel_t     wb_sel
);

    instr_class_t instr_class;                              // Shared by sequencer and output stage

    instr_decoder decoder_i (
        .instruction (instruction),
        .instr_class (instr_class)
    );

    control_sequencer sequencer_i (
        .clock       (clock),
        .reset       (reset),
        .instr_class (instr_class),
        .state       (state)
    );

    datapath_control outputs_i (
        .clock          (clock),
        .reset          (reset),
        .state          (state),
        .instr_class    (instr_class),
        .igual          (igual),
        .menor          (menor),
        .pc_write       (pc_write),
        .operand_latch  (operand_latch),
        .clear_a        (clear_a),
        .reg_file_wr    (reg_file_wr),
        .data_memory_wr (data_memory_wr),
        .mem_data_wr    (mem_data_wr),
        .alu_op         (alu_op),
        .src_a          (src_a),
        .src_b          (src_b),
        .wb_sel         (wb_sel)
    );

endmodule

// File: verification/control_unit_assertions.sv
`timescale 1ns/1ps

module control_unit_assertions import control_pkg::*; (
    input logic        clock,
    input logic        reset,
    input ctrl_state_t state
);

    int failure_count = 0;                                  // Number of failed sequencer checks

    state_legal: assert property (@(posedge clock) disable iff (reset)
        state inside {state_fetch, state_decode, state_branch, state_write_back,
                      state_mem_write_back, state_compare, state_mem_read,
                      state_mem_write, state_wait})
    else begin
        $error("state holds an unused encoding %h", state);
        failure_count++;
    end

    // Fetch never stalls
    fetch_to_decode: assert property (@(posedge clock) disable iff (reset)
        state == state_fetch |=> state == state_decode)
    else begin
        $error("fetch was not followed by decode");
        failure_count++;
    end

    mem_read_to_write_back: assert property (@(posedge clock) disable iff (reset)
        state == state_mem_read |=> state == state_mem_write_back)
    else begin
        $error("memory read was not followed by memory write-back");
        failure_count++;
    end

endmodule

bind control_sequencer control_unit_assertions assertions_i (
    .clock (clock),
    .reset (reset),
    .state (state)
);

// File: verification/control_unit_tb.sv
`timescale 1ns/1ps

module control_unit_tb import isa_pkg::*, control_pkg::*; ();

    localparam int half_period    = 50;                     // 100 ns clock
    localparam int reset_cycles   = 16;
    localparam int timeout_margin = 20;                     // Slack cycles past the vector count
    localparam int drive_delay    = 5;                      // Inputs change after the edge
    localparam int sample_delay   = 90;                     // Outputs read 5 ns before next edge

    logic        clock;
    logic        reset;
    logic        igual;
    logic        menor;
    instr_t      instruction;
    ctrl_state_t state;
    logic        pc_write;
    logic        operand_latch;
    logic        clear_a;
    logic        reg_file_wr;
    logic        data_memory_wr;
    logic        mem_data_wr;
    alu_op_t     alu_op;
    src_a_t      src_a;
    src_b_t      src_b;
    wb_sel_t     wb_sel;

    instr_t      vec_instr[$];
    logic [1:0]  vec_flags[$];                              // igual, menor
    logic [3:0]  vec_state[$];
    logic [4:0]  vec_strobes[$];                            // pc_write, rf_wr, dmem, mdr, clear_a
    logic [11:0] vec_selects[$];                            // alu_op, src_a, src_b, wb_sel
    int          cycle_count = 0;
    int          cycle_limit = 0;                           // Zero until vectors are loaded
    logic        expected_latch = 1'b0;                     // Operand latch level after reset
    string       step_name = "reset";

    control_unit dut_i (
        .clock          (clock),
        .reset          (reset),
        .igual          (igual),
        .menor          (menor),
        .instruction    (instruction),
        .state          (state),
        .pc_write       (pc_write),
        .operand_latch  (operand_latch),
        .clear_a        (clear_a),
        .reg_file_wr    (reg_file_wr),
        .data_memory_wr (data_memory_wr),
        .mem_data_wr    (mem_data_wr),
        .alu_op         (alu_op),
        .src_a          (src_a),
        .src_b          (src_b),
        .wb_sel         (wb_sel)
    );

    always #half_period clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin   // Run went past all vectors
            $display("Timeout after %0d cycles, the vector replay did not finish", cycle_count);
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("TEST FAILED");
        $fatal(1, "run stopped at %s", step_name);
    endtask

    task automatic check_state(input ctrl_state_t expected, input ctrl_state_t actual);
        if (actual !== expected) begin
            $display("** Error: state expected %h, got %h at %s", expected, actual, step_name);
            stop_with_failure();
        end
    endtask

    task automatic check_strobe(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h, got %h at %s", name, expected, actual, step_name);
            stop_with_failure();
        end
    endtask

    task automatic check_alu_op(input alu_op_t expected, input alu_op_t actual);
        if (actual !== expected) begin
            $display("** Error: alu_op expected %h, got %h at %s", expected, actual, step_name);
            stop_with_failure();
        end
    endtask

    task automatic check_src_a(input src_a_t expected, input src_a_t actual);
        if (actual !== expected) begin
            $display("** Error: src_a expected %h, got %h at %s", expected, actual, step_name);
            stop_with_failure();
        end
    endtask

    task automatic check_src_b(input src_b_t expected, input src_b_t actual);
        if (actual !== expected) begin
            $display("** Error: src_b expected %h, got %h at %s", expected, actual, step_name);
            stop_with_failure();
        end
    endtask

    task automatic check_wb_sel(input wb_sel_t expected, input wb_sel_t actual);
        if (actual !== expected) begin
            $display("** Error: wb_sel expected %h, got %h at %s", expected, actual, step_name);
            stop_with_failure();
        end
    endtask

    // One vector per line and comment lines start with a slash
    task automatic read_vectors();
        int          fd;
        int          status;
        int          fields;
        string       line;
        logic [31:0] f [13];
        fd = $fopen("verification/control_unit_vectors.txt", "r");
        if (fd == 0) begin
            $display("The vector file could not be opened");
            stop_with_failure();
        end
        while (!$feof(fd)) begin
            status = $fgets(line, fd);
            if (status != 0 && line.len() > 1 && line[0] != "/") begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                                 f[7], f[8], f[9], f[10], f[11], f[12]);
                if (fields != 13) begin
                    $display("A vector line holds %0d fields instead of 13", fields);
                    stop_with_failure();
                end
                vec_instr.push_back(f[0]);
                vec_flags.push_back({f[1][0], f[2][0]});
                vec_state.push_back(f[3][3:0]);
                vec_strobes.push_back({f[4][0], f[5][0], f[6][0], f[7][0], f[8][0]});
                vec_selects.push_back({f[9][2:0], f[10][2:0], f[11][2:0], f[12][2:0]});
            end
        end
        $fclose(fd);
    endtask

    // Latch drops when fetch is left, rises when decode is left, else holds
    task automatic update_latch_expectation(input int index);
        if (index > 0) begin
            if (ctrl_state_t'(vec_state[index - 1]) == state_fetch) begin
                expected_latch = 1'b0;
            end else if (ctrl_state_t'(vec_state[index - 1]) == state_decode) begin
                expected_latch = 1'b1;
            end
        end
    endtask

    task automatic check_outputs(input int index);
        update_latch_expectation(index);
        check_state(ctrl_state_t'(vec_state[index]), state);
        check_strobe("pc_write", vec_strobes[index][4], pc_write);
        check_strobe("reg_file_wr", vec_strobes[index][3], reg_file_wr);
        check_strobe("data_memory_wr", vec_strobes[index][2], data_memory_wr);
        check_strobe("mem_data_wr", vec_strobes[index][1], mem_data_wr);
        check_strobe("clear_a", vec_strobes[index][0], clear_a);
        check_strobe("operand_latch", expected_latch, operand_latch);
        check_alu_op(alu_op_t'(vec_selects[index][11:9]), alu_op);
        check_src_a(src_a_t'(vec_selects[index][8:6]), src_a);
        check_src_b(src_b_t'(vec_selects[index][5:3]), src_b);
        check_wb_sel(wb_sel_t'(vec_selects[index][2:0]), wb_sel);
        if (dut_i.sequencer_i.assertions_i.failure_count != 0) begin
            $display("A sequencer assertion failed before %s", step_name);
            stop_with_failure();
        end
    endtask

    initial begin
        int index;
        clock       = 1'b0;
        reset       = 1'b1;
        igual       = 1'b0;
        menor       = 1'b0;
        instruction = 32'h0000_0013;                        // nop while in reset
        read_vectors();
        if (vec_instr.size() == 0) begin
            $display("The vector file holds no vectors");
            stop_with_failure();
        end
        cycle_limit = vec_instr.size() + reset_cycles + timeout_margin;
        repeat (reset_cycles) @(posedge clock);
        #drive_delay;
        check_state(state_fetch, state);                    // Reset values with clear_a held high
        check_strobe("pc_write", 1'b0, pc_write);
        check_strobe("reg_file_wr", 1'b0, reg_file_wr);
        check_strobe("data_memory_wr", 1'b0, data_memory_wr);
        check_strobe("mem_data_wr", 1'b0, mem_data_wr);
        check_strobe("operand_latch", 1'b0, operand_latch);
        check_strobe("clear_a", 1'b1, clear_a);
        check_alu_op(alu_pass_a, alu_op);
        check_wb_sel(wb_alu, wb_sel);
        reset = 1'b0;
        for (index = 0; index < vec_instr.size(); index++) begin
            step_name   = $sformatf("vector %0d", index);
            instruction = vec_instr[index];
            igual       = vec_flags[index][1];
            menor       = vec_flags[index][0];
            #sample_delay;                                  // Just before the next rising edge
            check_outputs(index);
            @(posedge clock);
            #drive_delay;
        end
        if (dut_i.sequencer_i.assertions_i.failure_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("A sequencer assertion failed at the last clock edge");
            stop_with_failure();
        end
    end

endmodule

// File: list.f
rtl/isa_pkg.sv
rtl/control_pkg.sv
rtl/instr_decoder.sv
rtl/control_sequencer.sv
rtl/datapath_control.sv
rtl/control_unit.sv
verification/control_unit_assertions.sv
verification/control_unit_tb.sv

// File: verification/control_unit_vectors.txt
// instr igual menor | state pc_write reg_file_wr data_memory_wr mem_data_wr clear_a
// alu_op src_a src_b wb_sel, all hex, one line per clock cycle after reset release
002081b3 0 0 1 0 0 0 0 1 0 0 0 0  // add, first cycle out of reset
002081b3 0 0 2 1 0 0 0 0 1 0 1 1
002081b3 0 0 4 0 0 0 0 0 1 1 0 1
402081b3 0 0 1 0 1 0 0 0 1 1 0 0  // sub
402081b3 0 0 2 1 0 0 0 0 1 0 1 1
402081b3 0 0 4 0 0 0 0 0 2 1 0 1
0020f1b3 0 0 1 0 1 0 0 0 2 1 0 0  // and
0020f1b3 0 0 2 1 0 0 0 0 1 0 1 1
0020f1b3 0 0 4 0 0 0 0 0 3 1 0 1
00508193 0 0 1 0 1 0 0 0 3 1 0 0  // addi
00508193 0 0 2 1 0 0 0 0 1 0 1 1
00508193 0 0 4 0 0 0 0 0 1 1 2 1
123451b7 0 0 1 0 1 0 0 0 1 1 2 0  // lui
123451b7 0 0 2 1 0 0 0 0 1 0 1 1
123451b7 0 0 4 0 0 0 0 1 1 1 2 1
0020a1b3 0 1 1 0 1 0 0 0 1 1 2 0  // slt with menor set
0020a1b3 0 1 2 1 0 0 0 0 1 0 1 1
0020a1b3 0 1 6 0 0 0 0 0 7 1 0 1
0020a1b3 0 1 4 0 0 0 0 1 4 1 0 1
0050a193 0 0 1 0 1 0 0 0 4 1 0 0  // slti with menor clear
0050a193 0 0 2 1 0 0 0 0 1 0 1 1
0050a193 0 0 6 0 0 0 0 0 7 1 2 1
0050a193 0 0 4 0 0 0 0 1 0 1 2 1
0080a183 0 0 1 0 1 0 0 0 0 1 2 0  // lw
0080a183 0 0 2 1 0 0 0 0 1 0 1 1
0080a183 0 0 7 0 0 0 1 0 1 1 2 1
0080a183 0 0 5 0 0 0 0 0 1 1 2 1
0080a183 0 0 9 0 1 0 0 0 1 1 2 1
0020a423 0 0 1 0 0 0 0 0 1 1 2 1  // sw
0020a423 0 0 2 1 0 0 0 0 1 0 1 1
0020a423 0 0 8 0 0 0 0 0 1 1 2 1
00208463 1 0 1 0 0 1 0 0 1 1 2 1  // beq taken
00208463 1 0 2 1 0 0 0 0 1 0 1 1
00208463 1 0 3 0 0 0 0 0 7 1 0 1
00208463 0 0 1 1 0 0 0 0 1 0 3 1  // beq not taken
00208463 0 0 2 1 0 0 0 0 1 0 1 1
00208463 0 0 3 0 0 0 0 0 7 1 0 1
00209467 0 0 1 0 0 0 0 0 7 1 0 1  // bne taken
00209467 0 0 2 1 0 0 0 0 1 0 1 1
00209467 0 0 3 0 0 0 0 0 7 1 0 1
00209467 1 0 1 1 0 0 0 0 1 0 3 1  // bne not taken
00209467 1 0 2 1 0 0 0 0 1 0 1 1
00209467 1 0 3 0 0 0 0 0 7 1 0 1
0020d467 0 0 1 0 0 0 0 0 7 1 0 1  // bge taken
0020d467 0 0 2 1 0 0 0 0 1 0 1 1
0020d467 0 0 3 0 0 0 0 0 7 1 0 1
0020d467 0 1 1 1 0 0 0 0 1 0 3 1  // bge not taken
0020d467 0 1 2 1 0 0 0 0 1 0 1 1
0020d467 0 1 3 0 0 0 0 0 7 1 0 1
0020c467 0 1 1 0 0 0 0 0 7 1 0 1  // blt taken
0020c467 0 1 2 1 0 0 0 0 1 0 1 1
0020c467 0 1 3 0 0 0 0 0 7 1 0 1
0020c467 0 0 1 1 0 0 0 0 1 0 3 1  // blt not taken
0020c467 0 0 2 1 0 0 0 0 1 0 1 1
0020c467 0 0 3 0 0 0 0 0 7 1 0 1
010000ef 0 0 1 0 0 0 0 0 7 1 0 1  // jal
010000ef 0 0 2 1 0 0 0 0 1 0 1 1
010000ef 0 0 4 0 0 0 0 0 0 0 1 1
010000ef 0 0 3 0 1 0 0 0 0 0 1 0
004100e7 0 0 1 1 0 0 0 0 1 0 3 0  // jalr
004100e7 0 0 2 1 0 0 0 0 1 0 1 1
004100e7 0 0 4 0 0 0 0 0 0 0 1 1
004100e7 0 0 3 0 1 0 0 0 0 0 1 0
00000013 0 0 1 1 0 0 0 0 1 1 2 0  // nop
00000013 0 0 2 1 0 0 0 0 1 0 1 1
00109193 0 0 1 0 0 0 0 0 1 0 1 1  // slli, now illegal
00109193 0 0 2 1 0 0 0 0 1 0 1 1
00100073 0 0 1 0 0 0 0 0 1 0 1 1  // break parks in decode
00100073 0 0 2 1 0 0 0 0 1 0 1 1
00100073 0 0 2 0 0 0 0 0 1 0 1 1
00100073 0 0 2 0 0 0 0 0 1 0 1 1
